// File: source/branchPred_defines.svh
`ifndef BRANCH_PRED_DEFINES_SVH
`define BRANCH_PRED_DEFINES_SVH

// ######################################################################
// branch prediction sizing
// ######################################################################

// branch execution units that can send a target update in one cycle
`define BP_NUM_IN 2

// direct-mapped target buffer, must be a power of two
`define BTB_ENTRIES 32

// TAGE base table depth, power of two
`define TAGE_BASE_ENTRIES 64

// depth of the single tagged table, power of two
`define TAGE_TAGGED_ENTRIES 64

// tag width stored in each tagged entry
`define TAGE_TAG_BITS 8

// global history length, newest outcome sits in bit 0
`define HIST_BITS 8

`endif

// File: source/branchPredPkg.sv
`include "branchPred_defines.svh"

package branchPredPkg;

    // ##################################################################
    // history and counters
    // ##################################################################

    typedef logic [`HIST_BITS-1:0] BHist;  // bit 0 holds the newest outcome

    // saturating 2-bit counter, the upper bit gives the direction
    typedef enum logic [1:0] {
        StrongNotTaken = 2'b00,
        WeakNotTaken   = 2'b01,
        WeakTaken      = 2'b10,
        StrongTaken    = 2'b11
    } TageCounter;

    // ##################################################################
    // records passed between fetch, execute and commit
    // ##################################################################

    typedef struct packed {
        logic predicted;   // the BTB found a branch at this fetch
        logic taken;       // final predicted direction
        logic isJump;
        logic tageID;      // tagged table gave the direction
        logic tageUseful;
    } BranchPredInfo;

    typedef struct packed {
        logic        valid;
        logic [30:0] src;  // halfword address of the branch
        logic [30:0] dst;
        logic        isJump;
        logic        compressed;
    } BTUpdate;

    typedef struct packed {
        logic          valid;
        logic          isBranch;
        logic          branchTaken;
        logic [30:0]   pc;
        BHist          history;  // history seen when the branch was predicted
        BranchPredInfo bpi;
    } CommitUOp;

    typedef struct packed {
        logic taken;    // redirect strobe
        BHist history;
    } BranchProv;

endpackage

// File: source/branchTargetBuffer.sv
`timescale 1ns/1ps
`include "branchPred_defines.svh"

module branchTargetBuffer (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  pcValid,
    input  logic [30:0]           pc,

    input  branchPredPkg::BTUpdate btUpdate,

    output logic                  branchFound,
    output logic                  branchIsJump,
    output logic                  branchCompr,
    output logic [30:0]           branchSrc,
    output logic [30:0]           branchDst
);

    import branchPredPkg::*;

    localparam int idxBits = $clog2(`BTB_ENTRIES);
    localparam int tagBits = 31 - idxBits;

    typedef struct packed {
        logic [tagBits-1:0] tag;
        logic [30:0]        dst;
        logic               isJump;
        logic               compr;
    } BtbEntry;

    // ##################################################################
    // storage
    // ##################################################################

    BtbEntry                  entries [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0]  entryValid;

    logic [idxBits-1:0]       lookIdx;
    logic [tagBits-1:0]       lookTag;
    BtbEntry                  lookEntry;
    logic                     lookHit;

    logic [idxBits-1:0]       upIdx;
    BtbEntry                  upEntry;

    assign lookIdx   = pc[idxBits-1:0];
    assign lookTag   = pc[30:idxBits];
    assign lookEntry = entries[lookIdx];
    assign lookHit   = entryValid[lookIdx] && (lookEntry.tag == lookTag);

    assign upIdx = btUpdate.src[idxBits-1:0];

    always_comb begin
        upEntry.tag    = btUpdate.src[30:idxBits];
        upEntry.dst    = btUpdate.dst;
        upEntry.isJump = btUpdate.isJump;
        upEntry.compr  = btUpdate.compressed;
    end

    // ##################################################################
    // update port
    // ##################################################################

    // an update replaces whatever lived in the slot
    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (btUpdate.valid) begin
            entryValid[upIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btUpdate.valid) begin
            entries[upIdx] <= upEntry;
        end
    end

    // ##################################################################
    // registered lookup
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            branchFound <= 1'b0;
        end else if (pcValid) begin
            branchFound <= lookHit;
        end
    end

    // results are held between valid lookups
    always_ff @(posedge clk) begin
        if (pcValid) begin
            branchSrc    <= {lookEntry.tag, lookIdx};  // equals pc on a hit
            branchDst    <= lookEntry.dst;
            branchIsJump <= lookEntry.isJump;
            branchCompr  <= lookEntry.compr;
        end
    end

endmodule

// File: source/tagePredictor.sv
`timescale 1ns/1ps
`include "branchPred_defines.svh"

module tagePredictor (
    input  logic                clk,
    input  logic                rst,

    // prediction side, read is combinational
    input  logic [30:0]         predAddr,
    input  branchPredPkg::BHist predHistory,
    output logic                predTageID,
    output logic                predUseful,
    output logic                predTaken,

    // training side, from commit
    input  logic                writeValid,
    input  logic [30:0]         writeAddr,
    input  branchPredPkg::BHist writeHistory,
    input  logic                writeTageID,
    input  logic                writeTaken,
    input  logic                writeUseful,
    input  logic                writePred
);

    import branchPredPkg::*;

    localparam int baseIdxBits = $clog2(`TAGE_BASE_ENTRIES);
    localparam int tagIdxBits  = $clog2(`TAGE_TAGGED_ENTRIES);

    // ##################################################################
    // helpers
    // ##################################################################

    // history is folded onto the index width, then mixed with the address
    function automatic logic [tagIdxBits-1:0] taggedIndex(input logic [30:0] addr,
                                                          input BHist hist);
        logic [tagIdxBits-1:0] idx;
        idx = addr[tagIdxBits-1:0];
        for (int i = 0; i < `HIST_BITS; i++) begin
            idx[i % tagIdxBits] = idx[i % tagIdxBits] ^ hist[i];
        end
        return idx;
    endfunction

    function automatic logic [`TAGE_TAG_BITS-1:0] taggedTag(input logic [30:0] addr);
        return addr[tagIdxBits +: `TAGE_TAG_BITS];
    endfunction

    function automatic TageCounter stepCounter(input TageCounter cnt, input logic taken);
        TageCounter next;
        next = cnt;
        if (taken && cnt != StrongTaken) begin
            next = TageCounter'(cnt + 2'd1);
        end else if (!taken && cnt != StrongNotTaken) begin
            next = TageCounter'(cnt - 2'd1);
        end
        return next;
    endfunction

    // ##################################################################
    // tables
    // ##################################################################

    TageCounter                      baseCnts [`TAGE_BASE_ENTRIES];

    logic [`TAGE_TAGGED_ENTRIES-1:0] tagValid;
    logic [`TAGE_TAGGED_ENTRIES-1:0] tagUseful;
    logic [`TAGE_TAG_BITS-1:0]       tagTags [`TAGE_TAGGED_ENTRIES];
    TageCounter                      tagCnts [`TAGE_TAGGED_ENTRIES];

    // ##################################################################
    // prediction
    // ##################################################################

    logic [baseIdxBits-1:0] pBaseIdx;
    logic [tagIdxBits-1:0]  pTagIdx;
    logic                   pHit;

    assign pBaseIdx = predAddr[baseIdxBits-1:0];
    assign pTagIdx  = taggedIndex(predAddr, predHistory);
    assign pHit     = tagValid[pTagIdx] && (tagTags[pTagIdx] == taggedTag(predAddr));

    assign predTageID = pHit;
    assign predUseful = pHit && tagUseful[pTagIdx];
    assign predTaken  = pHit ? tagCnts[pTagIdx][1] : baseCnts[pBaseIdx][1];

    // ##################################################################
    // training
    // ##################################################################

    logic [baseIdxBits-1:0] wBaseIdx;
    logic [tagIdxBits-1:0]  wTagIdx;
    logic                   wCorrect;
    logic                   tagTrain;
    logic                   allocate;

    assign wBaseIdx = writeAddr[baseIdxBits-1:0];
    assign wTagIdx  = taggedIndex(writeAddr, writeHistory);
    assign wCorrect = (writePred == writeTaken);
    assign tagTrain = writeValid && writeTageID;
    // base table got it wrong, take the tagged slot unless it is still earning its keep
    assign allocate = writeValid && !writeTageID && !wCorrect && !tagUseful[wTagIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TAGE_BASE_ENTRIES; i++) begin
                baseCnts[i] <= WeakNotTaken;
            end
        end else if (writeValid && !writeTageID) begin
            baseCnts[wBaseIdx] <= stepCounter(baseCnts[wBaseIdx], writeTaken);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tagValid  <= '0;
            tagUseful <= '0;
        end else if (allocate) begin
            tagValid[wTagIdx]  <= 1'b1;
            tagUseful[wTagIdx] <= 1'b0;
        end else if (tagTrain && (wCorrect != writeUseful)) begin
            tagUseful[wTagIdx] <= wCorrect;  // only touched when the bit flips
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            tagTags[wTagIdx] <= taggedTag(writeAddr);
            tagCnts[wTagIdx] <= writeTaken ? WeakTaken : WeakNotTaken;
        end else if (tagTrain) begin
            tagCnts[wTagIdx] <= stepCounter(tagCnts[wTagIdx], writeTaken);
        end
    end

endmodule

// File: source/branchPredictor.sv
`timescale 1ns/1ps
`include "branchPred_defines.svh"

module branchPredictor (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mispredFlush,
    input  branchPredPkg::BranchProv      branch,

    // fetch side
    input  logic                          pcValid,
    input  logic [31:0]                   pc,
    output logic                          branchTaken,
    output logic                          isJump,
    output logic                          branchFound,
    output logic                          branchCompr,
    output logic [31:0]                   branchSrc,
    output logic [31:0]                   branchDst,
    output branchPredPkg::BHist           branchHistory,
    output branchPredPkg::BranchPredInfo  branchInfo,

    // branch execution units
    input  branchPredPkg::BTUpdate        btUpdates [`BP_NUM_IN-1:0],

    // commit side
    input  branchPredPkg::CommitUOp       comUOp,
    output logic                          branchCommitted
);

    import branchPredPkg::*;

    BHist        gHistory;
    BTUpdate     btUpdate;
    logic [30:0] srcHw;
    logic [30:0] dstHw;
    logic [30:0] branchAddr;
    logic        tageTaken;
    logic        tageId;
    logic        tageUseful;
    logic        commitValid;

    // ##################################################################
    // update selection
    // ##################################################################

    always_comb begin
        btUpdate = '0;
        for (int i = 0; i < `BP_NUM_IN; i++) begin
            if (btUpdates[i].valid) btUpdate = btUpdates[i];  // highest index wins
        end
    end

    // ##################################################################
    // predictors
    // ##################################################################

    branchTargetBuffer btb_i (
        .clk          (clk),
        .rst          (rst),
        .pcValid      (pcValid),
        .pc           (pc[31:1]),
        .btUpdate     (btUpdate),
        .branchFound  (branchFound),
        .branchIsJump (isJump),
        .branchCompr  (branchCompr),
        .branchSrc    (srcHw),
        .branchDst    (dstHw)
    );

    // uncompressed branches are looked up by their first halfword
    assign branchAddr = branchCompr ? srcHw : srcHw - 31'd1;

    assign commitValid = comUOp.valid && comUOp.isBranch && !mispredFlush;

    tagePredictor tage_i (
        .clk          (clk),
        .rst          (rst),
        .predAddr     (branchAddr),
        .predHistory  (gHistory),
        .predTageID   (tageId),
        .predUseful   (tageUseful),
        .predTaken    (tageTaken),
        .writeValid   (commitValid && comUOp.bpi.predicted),
        .writeAddr    (comUOp.pc),
        .writeHistory (comUOp.history),
        .writeTageID  (comUOp.bpi.tageID),
        .writeTaken   (comUOp.branchTaken),
        .writeUseful  (comUOp.bpi.tageUseful),
        .writePred    (comUOp.bpi.taken)
    );

    // ##################################################################
    // outputs, history and commit strobe
    // ##################################################################

    assign branchTaken   = branchFound && (isJump || tageTaken);
    assign branchSrc     = {srcHw, 1'b0};
    assign branchDst     = {dstHw, 1'b0};
    assign branchHistory = gHistory;

    assign branchInfo.predicted  = branchFound;
    assign branchInfo.taken      = branchTaken;
    assign branchInfo.isJump     = isJump;
    assign branchInfo.tageID     = tageId;
    assign branchInfo.tageUseful = tageUseful;

    always_ff @(posedge clk) begin
        if (rst) begin
            gHistory        <= '0;
            branchCommitted <= 1'b0;
        end else begin
            if (branch.taken) begin
                gHistory <= branch.history;  // a redirect beats the speculative shift
            end else if (branchFound && !isJump) begin
                gHistory <= {gHistory[`HIST_BITS-2:0], branchTaken};
            end
            branchCommitted <= commitValid;
        end
    end

endmodule

// File: dv/branchPredictorTests.svh
`ifndef BRANCH_PREDICTOR_TESTS_SVH
`define BRANCH_PREDICTOR_TESTS_SVH

// ######################################################################
// reference model state
// ######################################################################

logic        btbValid [`BTB_ENTRIES];
logic [30:0] btbSrc [`BTB_ENTRIES];
logic [30:0] btbDst [`BTB_ENTRIES];
logic        btbJump [`BTB_ENTRIES];
logic        btbCompr [`BTB_ENTRIES];
int          baseCnt [`TAGE_BASE_ENTRIES];
logic [30:0] allocAddr [$];  // tagged entries, one per (address, history) pair
BHist        allocHist [$];
int          allocCnt [$];

localparam logic [30:0] missPc = 31'd31;  // index 31 is never written
logic [30:0] jumpSrc;

task automatic stepCycle();
    @(posedge clk);
    #2;
endtask

task automatic idleInputs();
    pcValid      = 1'b0;
    pc           = '0;
    branch       = '0;
    mispredFlush = 1'b0;
    comUOp       = '0;
    for (int i = 0; i < `BP_NUM_IN; i++) begin
        btUpdates[i] = '0;
    end
endtask

task automatic resetModel();
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
        btbValid[i] = 1'b0;
    end
    for (int i = 0; i < `TAGE_BASE_ENTRIES; i++) begin
        baseCnt[i] = 1;  // weakly not taken
    end
endtask

// random halfword address that lands on a chosen BTB index
function automatic logic [30:0] makeSrc(input logic [4:0] idx);
    logic [31:0] r;
    r = $urandom;
    r[4:0] = idx;
    return r[30:0];
endfunction

function automatic logic predictDir(input logic [30:0] addr, input BHist hist,
                                    output logic hit);
    hit = 1'b0;
    predictDir = baseCnt[addr[5:0]] >= 2;
    for (int i = 0; i < allocAddr.size(); i++) begin
        if (allocAddr[i] == addr && allocHist[i] == hist) begin
            hit = 1'b1;
            predictDir = allocCnt[i] >= 2;
        end
    end
endfunction

task automatic writeBtb(input int port, input logic [30:0] src, input logic [30:0] dst,
                        input logic jump, input logic compr);
    btUpdates[port] = '{valid: 1'b1, src: src, dst: dst, isJump: jump, compressed: compr};
    btbValid[src[4:0]] = 1'b1;  // later ports overwrite, as the DUT does
    btbSrc[src[4:0]]   = src;
    btbDst[src[4:0]]   = dst;
    btbJump[src[4:0]]  = jump;
    btbCompr[src[4:0]] = compr;
endtask

task automatic applyUpdates();
    stepCycle();
    idleInputs();
endtask

task automatic lookup(input logic [30:0] pcHw, input logic redirect, input BHist hist);
    pc             = {pcHw, 1'b0};
    pcValid        = 1'b1;
    branch.taken   = redirect;
    branch.history = hist;
    stepCycle();
    pcValid = 1'b0;
    branch  = '0;
endtask

task automatic checkLookup(input logic [30:0] pcHw, input BHist hist);
    logic          hit;
    logic          found;
    logic          dir;
    logic [4:0]    i;
    logic [30:0]   addr;
    BranchPredInfo expInfo;
    i     = pcHw[4:0];
    found = btbValid[i] && btbSrc[i] == pcHw;
    checkValue("branchFound", 32'(branchFound), 32'(found));
    checkValue("branchHistory", 32'(branchHistory), 32'(hist));
    if (found) begin
        addr = btbCompr[i] ? pcHw : pcHw - 31'd1;
        dir  = predictDir(addr, hist, hit);
        // no commit trains a tagged entry in these tests, so none has become useful
        expInfo = '{predicted: 1'b1, taken: btbJump[i] || dir, isJump: btbJump[i],
                    tageID: hit, tageUseful: 1'b0};
        checkValue("branchSrc", branchSrc, {pcHw, 1'b0});
        checkValue("branchDst", branchDst, {btbDst[i], 1'b0});
        checkValue("isJump", 32'(isJump), 32'(btbJump[i]));
        checkValue("branchCompr", 32'(branchCompr), 32'(btbCompr[i]));
        checkValue("branchTaken", 32'(branchTaken), 32'(btbJump[i] || dir));
        checkValue("tageID", 32'(branchInfo.tageID), 32'(hit));
        checkValue("branchInfo", 32'(branchInfo), 32'(expInfo));
    end else begin
        checkValue("branchTaken", 32'(branchTaken), 32'd0);
        checkValue("branchInfo.predicted", 32'(branchInfo.predicted), 32'd0);
    end
endtask

task automatic commitBranch(input logic [30:0] addr, input BHist hist, input logic taken,
                            input logic predTaken, input logic flush);
    comUOp = '{valid: 1'b1, isBranch: 1'b1, branchTaken: taken, pc: addr, history: hist,
               bpi: '{predicted: 1'b1, taken: predTaken, isJump: 1'b0, tageID: 1'b0,
                      tageUseful: 1'b0}};
    mispredFlush = flush;
    if (!flush) begin
        if (taken && baseCnt[addr[5:0]] < 3) baseCnt[addr[5:0]]++;
        if (!taken && baseCnt[addr[5:0]] > 0) baseCnt[addr[5:0]]--;
        if (taken != predTaken) begin  // base mispredicted, tagged slot is taken over
            allocAddr.push_back(addr);
            allocHist.push_back(hist);
            allocCnt.push_back(taken ? 2 : 1);
        end
    end
    stepCycle();
    idleInputs();
    checkValue("branchCommitted", 32'(branchCommitted), 32'(!flush));
    stepCycle();
    checkValue("branchCommitted after pulse", 32'(branchCommitted), 32'd0);
endtask

// ######################################################################
// directed tests
// ######################################################################

task automatic testReset();
    int errBefore;
    errBefore = errorCount;
    lookup(makeSrc(5'd30), 1'b0, '0);
    checkLookup(pc[31:1], '0);
    checkValue("branchCommitted", 32'(branchCommitted), 32'd0);
    reportTest("reset", errBefore);
endtask

task automatic testBtb();
    int          errBefore;
    logic [30:0] s2;
    errBefore = errorCount;
    jumpSrc = makeSrc(5'd3);
    writeBtb(0, jumpSrc, makeSrc(5'd17), 1'b1, 1'b1);
    applyUpdates();
    lookup(jumpSrc, 1'b0, '0);
    checkLookup(jumpSrc, '0);
    lookup(missPc, 1'b0, '0);
    checkLookup(missPc, '0);
    s2 = makeSrc(5'd5);
    writeBtb(0, s2, makeSrc(5'd1), 1'b0, 1'b0);
    writeBtb(1, s2, makeSrc(5'd2), 1'b0, 1'b1);
    applyUpdates();
    lookup(s2, 1'b1, '0);  // redirect keeps the history at zero
    checkLookup(s2, '0);
    lookup(missPc, 1'b1, '0);
    reportTest("btb", errBefore);
endtask

task automatic testTage();
    int          errBefore;
    logic [30:0] s;
    errBefore = errorCount;
    s = makeSrc(5'd9);
    writeBtb(0, s, makeSrc(5'd4), 1'b0, 1'b1);
    applyUpdates();
    lookup(s, 1'b1, 8'h3c);
    checkLookup(s, 8'h3c);
    commitBranch(s, 8'h3c, 1'b1, 1'b0, 1'b0);
    lookup(s, 1'b1, 8'h3c);
    checkLookup(s, 8'h3c);
    checkValue("taken after allocation", 32'(branchTaken), 32'd1);
    lookup(missPc, 1'b0, '0);  // a taken conditional hit shifts in a one
    checkLookup(missPc, 8'h79);
    reportTest("tage", errBefore);
endtask

task automatic testHistory();
    int          errBefore;
    logic [30:0] s;
    errBefore = errorCount;
    s = makeSrc(5'd7);
    writeBtb(0, s, makeSrc(5'd6), 1'b0, 1'b1);
    applyUpdates();
    lookup(missPc, 1'b1, 8'h5a);
    checkLookup(missPc, 8'h5a);
    lookup(s, 1'b0, '0);
    checkLookup(s, 8'h5a);
    lookup(missPc, 1'b0, '0);  // not-taken conditional hit shifts in a zero
    checkLookup(missPc, 8'hb4);
    lookup(jumpSrc, 1'b0, '0);
    checkLookup(jumpSrc, 8'hb4);
    lookup(missPc, 1'b0, '0);
    checkLookup(missPc, 8'hb4);
    lookup(missPc, 1'b0, '0);
    checkLookup(missPc, 8'hb4);
    lookup(s, 1'b0, '0);
    lookup(s, 1'b1, 8'h33);  // redirect wins over the hit in this edge
    checkLookup(s, 8'h33);
    lookup(missPc, 1'b0, '0);
    checkLookup(missPc, 8'h66);
    reportTest("history", errBefore);
endtask

task automatic testFlush();
    int          errBefore;
    logic [30:0] s;
    errBefore = errorCount;
    s = makeSrc(5'd11);
    writeBtb(0, s, makeSrc(5'd8), 1'b0, 1'b1);
    applyUpdates();
    lookup(s, 1'b1, 8'hc3);
    checkLookup(s, 8'hc3);
    commitBranch(s, 8'hc3, 1'b1, 1'b0, 1'b1);
    lookup(s, 1'b1, 8'hc3);
    checkLookup(s, 8'hc3);
    checkValue("taken after flushed commit", 32'(branchTaken), 32'd0);
    reportTest("flush", errBefore);
endtask

`endif

// File: dv/branchPredictorTb.sv
`timescale 1ns/1ps
`include "branchPred_defines.svh"

module branchPredictorTb;

    import branchPredPkg::*;

    localparam int maxCycles = 2000;  // far beyond the whole directed test sequence

    logic          clk;
    logic          rst;
    logic          mispredFlush;
    BranchProv     branch;
    logic          pcValid;
    logic [31:0]   pc;
    logic          branchTaken;
    logic          isJump;
    logic          branchFound;
    logic          branchCompr;
    logic [31:0]   branchSrc;
    logic [31:0]   branchDst;
    BHist          branchHistory;
    BranchPredInfo branchInfo;
    BTUpdate       btUpdates [`BP_NUM_IN-1:0];
    CommitUOp      comUOp;
    logic          branchCommitted;

    int errorCount;
    int testCount;
    int failedTests;
    int cycleCount;

    branchPredictor branchPredictor_i (
        .clk             (clk),
        .rst             (rst),
        .mispredFlush    (mispredFlush),
        .branch          (branch),
        .pcValid         (pcValid),
        .pc              (pc),
        .branchTaken     (branchTaken),
        .isJump          (isJump),
        .branchFound     (branchFound),
        .branchCompr     (branchCompr),
        .branchSrc       (branchSrc),
        .branchDst       (branchDst),
        .branchHistory   (branchHistory),
        .branchInfo      (branchInfo),
        .btUpdates       (btUpdates),
        .comUOp          (comUOp),
        .branchCommitted (branchCommitted)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("run timed out after %0d cycles", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        if (errorCount == errBefore) begin
            $display("test %s: pass", name);
        end else begin
            failedTests++;
            $display("test %s: fail with %0d errors", name, errorCount - errBefore);
        end
    endtask

`include "branchPredictorTests.svh"

    // ######################################################################
    // test sequence
    // ######################################################################

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        cycleCount  = 0;
        idleInputs();
        resetModel();
        void'($urandom(32'hfcd265ac));
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;

        testReset();
        testBtb();
        testTage();
        testHistory();
        testFlush();

        $display("tests run %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+source
+incdir+dv
source/branchPredPkg.sv
source/branchTargetBuffer.sv
source/tagePredictor.sv
source/branchPredictor.sv
dv/branchPredictorTb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for failures
verilator --binary --timing -f files.f --top-module branchPredictorTb \
    -Mdir obj_dir -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 \
    || { grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1; }
